//--- hw/qs_pkg.sv
// Shared definitions for the two-bank packet sorter
//   word width, bank depth and bank count
//   bank status and scoreboard entry
//   RAM write and read port structs
//   bank rotation helper
package qs_pkg;

  // Data word width
  localparam int W = 32;
  // Words per bank
  localparam int N = 16;
  // Banks in rotation
  localparam int BANKS = 2;

  typedef logic [W-1:0] w_t;
  typedef logic [$clog2(N)-1:0] addr_t;
  typedef logic [$clog2(BANKS)-1:0] bank_id_t;

  // Each status has exactly one stage allowed to leave it
  typedef enum logic [2:0] {
    BANK_READY     = 3'd0,
    BANK_LOADING   = 3'd1,
    BANK_LOADED    = 3'd2,
    BANK_SORTING   = 3'd3,
    BANK_SORTED    = 3'd4,
    BANK_UNLOADING = 3'd5
  } bank_status_t;

  // Scoreboard entry, n is the index of the last valid word
  typedef struct packed {
    bank_status_t status;
    addr_t        n;
    logic         err;
  } bank_state_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    w_t    dat;
  } wr_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } rd_t;

  // Next bank in strict rotation
  function automatic bank_id_t bank_id_inc(bank_id_t id);
    bank_id_t nxt;
    if (id == bank_id_t'(BANKS - 1)) begin
      nxt = '0;
    end else begin
      nxt = id + 1'b1;
    end
    return nxt;
  endfunction

endpackage

//--- hw/qs_bank_ram.sv
// Single sorter bank
//   one write port, one registered read port
//   read during write to the same word returns the old word
`timescale 1ns/1ps

module qs_bank_ram import qs_pkg::*; #(
  parameter int N_WORDS = 16
) (
  input  logic clk,
  input  wr_t  wr,
  input  rd_t  rd,
  output w_t   rd_data
);

  w_t mem [N_WORDS];

  // Write port
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.dat;
    end
  end

  // Read port, data one cycle after enable
  always_ff @(posedge clk) begin
    if (rd.en) begin
      rd_data <= mem[rd.addr];
    end
  end

endmodule

//--- hw/qs_enq.sv
// Decode stage of the sorter
//   takes packet words from the input strobes
//   writes them into the current load bank
//   publishes LOADING and LOADED to the scoreboard
`timescale 1ns/1ps

module qs_enq import qs_pkg::*; #(
  parameter int N_WORDS = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_vld,
  input  logic        in_sop,
  input  logic        in_eop,
  input  logic        in_err,
  input  w_t          in_dat,
  output logic        in_full,
  input  bank_state_t bank_in,
  output bank_id_t    bank_idx_r,
  output logic        bank_out_vld,
  output bank_state_t bank_out,
  output wr_t         wr
);

  // One extra bit so the count can reach N_WORDS
  localparam int CW = $clog2(N_WORDS) + 1;

  logic          open_q;
  logic [CW-1:0] cnt_q;
  logic          err_q;
  logic          sop_take;
  logic          word_take;
  logic          room;

  // Source may only start a packet into a free bank
  assign in_full   = (bank_in.status != BANK_READY) && !open_q;
  assign sop_take  = in_vld && in_sop && !in_full;
  assign word_take = in_vld && !in_sop && open_q;
  // Bank still has space for this word
  assign room      = cnt_q < CW'(N_WORDS);

  always_comb begin
    wr           = '0;
    bank_out_vld = 1'b0;
    bank_out     = bank_in;
    if (sop_take) begin
      // First word always lands on address 0
      wr.en           = 1'b1;
      wr.addr         = '0;
      wr.dat          = in_dat;
      bank_out_vld    = 1'b1;
      bank_out.status = in_eop ? BANK_LOADED : BANK_LOADING;
      bank_out.n      = '0;
      bank_out.err    = in_err;
    end else if (word_take) begin
      // Words past the bank depth are dropped
      wr.en   = room;
      wr.addr = addr_t'(cnt_q);
      wr.dat  = in_dat;
      if (in_eop) begin
        bank_out_vld    = 1'b1;
        bank_out.status = BANK_LOADED;
        bank_out.n      = room ? addr_t'(cnt_q) : addr_t'(N_WORDS - 1);
        // Truncation is reported as an error
        bank_out.err    = err_q || in_err || !room;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      open_q     <= 1'b0;
      cnt_q      <= '0;
      err_q      <= 1'b0;
      bank_idx_r <= '0;
    end else begin
      if (sop_take) begin
        open_q <= !in_eop;
        cnt_q  <= CW'(1);
        err_q  <= in_err;
      end else if (word_take) begin
        if (in_eop) begin
          open_q <= 1'b0;
        end
        // Saturate at the depth
        if (room) begin
          cnt_q <= cnt_q + 1'b1;
        end
        err_q <= err_q || in_err || !room;
      end
      // Move on to the next bank once the packet is closed
      if ((sop_take || word_take) && in_eop) begin
        bank_idx_r <= bank_id_inc(bank_idx_r);
      end
    end
  end

endmodule

//--- hw/qs_sort.sv
// Execute stage of the sorter
//   in-place bubble sort of a loaded bank
//   FSM with idle, prime, pass and flush states
//   publishes SORTING and SORTED to the scoreboard
`timescale 1ns/1ps

module qs_sort import qs_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  bank_state_t bank_in,
  output bank_id_t    bank_idx_r,
  output logic        bank_out_vld,
  output bank_state_t bank_out,
  output rd_t         rd,
  input  w_t          rd_data,
  output wr_t         wr
);

  typedef enum logic [1:0] {
    fsm_idle,
    fsm_prime,
    fsm_pass,
    fsm_flush
  } fsm_t;

  fsm_t  fsm_q;
  // Next read address within the pass
  addr_t addr_q;
  // Completed passes
  addr_t pass_q;
  // Largest word seen in this pass
  w_t    held_q;
  w_t    lo;
  w_t    hi;

  // Unsigned compare of incoming word against held word
  assign lo = (rd_data < held_q) ? rd_data : held_q;
  assign hi = (rd_data < held_q) ? held_q : rd_data;

  always_comb begin
    bank_out_vld = 1'b0;
    bank_out     = bank_in;
    rd           = '0;
    wr           = '0;
    case (fsm_q)
      fsm_idle: begin
        if (bank_in.status == BANK_LOADED) begin
          bank_out_vld    = 1'b1;
          // Single word needs no passes
          bank_out.status = (bank_in.n == '0) ? BANK_SORTED : BANK_SORTING;
        end
      end
      fsm_prime: begin
        // Held word of the previous pass goes to the top
        if (pass_q != '0) begin
          wr.en   = 1'b1;
          wr.addr = bank_in.n;
          wr.dat  = held_q;
        end
        if (pass_q == bank_in.n) begin
          bank_out_vld    = 1'b1;
          bank_out.status = BANK_SORTED;
        end else begin
          rd.en   = 1'b1;
          rd.addr = '0;
        end
      end
      fsm_pass: begin
        rd.en   = 1'b1;
        rd.addr = addr_q;
        // Smaller word drops one slot behind the read data
        if (addr_q != addr_t'(1)) begin
          wr.en   = 1'b1;
          wr.addr = addr_q - addr_t'(2);
          wr.dat  = lo;
        end
      end
      fsm_flush: begin
        // Last word of the pass arrives
        wr.en   = 1'b1;
        wr.addr = bank_in.n - addr_t'(1);
        wr.dat  = lo;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q      <= fsm_idle;
      addr_q     <= '0;
      pass_q     <= '0;
      bank_idx_r <= '0;
    end else begin
      case (fsm_q)
        fsm_idle: begin
          if (bank_in.status == BANK_LOADED) begin
            if (bank_in.n == '0) begin
              bank_idx_r <= bank_id_inc(bank_idx_r);
            end else begin
              pass_q <= '0;
              fsm_q  <= fsm_prime;
            end
          end
        end
        fsm_prime: begin
          if (pass_q == bank_in.n) begin
            bank_idx_r <= bank_id_inc(bank_idx_r);
            fsm_q      <= fsm_idle;
          end else begin
            addr_q <= addr_t'(1);
            fsm_q  <= fsm_pass;
          end
        end
        fsm_pass: begin
          addr_q <= addr_q + 1'b1;
          if (addr_q == bank_in.n) begin
            fsm_q <= fsm_flush;
          end
        end
        fsm_flush: begin
          pass_q <= pass_q + 1'b1;
          fsm_q  <= fsm_prime;
        end
        default: begin
          fsm_q <= fsm_idle;
        end
      endcase
    end
  end

  // Word 0 seeds the pass, later words keep the maximum
  always_ff @(posedge clk) begin
    if ((fsm_q == fsm_pass) && (addr_q == addr_t'(1))) begin
      held_q <= rd_data;
    end else if ((fsm_q == fsm_pass) || (fsm_q == fsm_flush)) begin
      held_q <= hi;
    end
  end

endmodule

//--- hw/qs_deq.sv
// Result stage of the sorter
//   unloads a sorted bank as an output packet
//   flag stage aligned with the RAM read latency
//   registered output stage with sop, eop and err
`timescale 1ns/1ps

module qs_deq import qs_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  output logic        out_vld_r,
  output logic        out_sop_r,
  output logic        out_eop_r,
  output logic        out_err_r,
  output w_t          out_dat_r,
  output bank_id_t    bank_idx_r,
  input  bank_state_t bank_in,
  output logic        bank_out_vld,
  output bank_state_t bank_out,
  output rd_t         rd,
  input  w_t          rd_data_r
);

  typedef enum logic [1:0] {
    fsm_idle,
    fsm_unload,
    fsm_wait_eop
  } fsm_t;

  typedef struct packed {
    logic sop;
    logic eop;
    logic err;
  } flags_t;

  fsm_t   fsm_q;
  addr_t  rd_addr_q;
  logic   last_rd;
  flags_t flg_d;
  // Flags travelling alongside the read
  logic   flg_vld_q;
  flags_t flg_q;
  // Output stage flags
  flags_t out_flg_q;

  assign last_rd = (rd_addr_q == bank_in.n);

  always_comb begin
    bank_out_vld = 1'b0;
    bank_out     = bank_in;
    rd           = '0;
    flg_d        = '0;
    case (fsm_q)
      fsm_idle: begin
        if (bank_in.status == BANK_SORTED) begin
          bank_out_vld    = 1'b1;
          bank_out.status = BANK_UNLOADING;
        end
      end
      fsm_unload: begin
        // One address per cycle, 0 up to n
        rd.en     = 1'b1;
        rd.addr   = rd_addr_q;
        flg_d.sop = (rd_addr_q == '0);
        flg_d.eop = last_rd;
        flg_d.err = bank_in.err;
        // Bank free again once the last read is out
        if (last_rd) begin
          bank_out_vld    = 1'b1;
          bank_out.status = BANK_READY;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fsm_q      <= fsm_idle;
      rd_addr_q  <= '0;
      bank_idx_r <= '0;
      flg_vld_q  <= 1'b0;
      flg_q      <= '0;
      out_vld_r  <= 1'b0;
      out_flg_q  <= '0;
    end else begin
      // Two-cycle pipe from read enable to output
      flg_vld_q <= rd.en;
      flg_q     <= flg_d;
      out_vld_r <= flg_vld_q;
      out_flg_q <= flg_q;
      case (fsm_q)
        fsm_idle: begin
          if (bank_in.status == BANK_SORTED) begin
            rd_addr_q <= '0;
            fsm_q     <= fsm_unload;
          end
        end
        fsm_unload: begin
          rd_addr_q <= rd_addr_q + 1'b1;
          if (last_rd) begin
            fsm_q <= fsm_wait_eop;
          end
        end
        fsm_wait_eop: begin
          // Hold the bank index until eop leaves
          if (out_vld_r && out_eop_r) begin
            bank_idx_r <= bank_id_inc(bank_idx_r);
            fsm_q      <= fsm_idle;
          end
        end
        default: begin
          fsm_q <= fsm_idle;
        end
      endcase
    end
  end

  // Output data word
  always_ff @(posedge clk) begin
    if (flg_vld_q) begin
      out_dat_r <= rd_data_r;
    end
  end

  assign out_sop_r = out_flg_q.sop;
  assign out_eop_r = out_flg_q.eop;
  assign out_err_r = out_flg_q.err;

endmodule

//--- hw/qs_banks.sv
// Bank scoreboard and storage
//   one state register per bank, updated by the owning stage
//   bank RAM instances
//   write and read port routing by bank status
`timescale 1ns/1ps

module qs_banks import qs_pkg::*; #(
  parameter int N_BANKS = 2,
  parameter int N_WORDS = 16
) (
  input  logic        clk,
  input  logic        rst,
  input  bank_id_t    enq_idx,
  input  bank_id_t    sort_idx,
  input  bank_id_t    deq_idx,
  input  logic        enq_upd_vld,
  input  logic        sort_upd_vld,
  input  logic        deq_upd_vld,
  input  bank_state_t enq_upd,
  input  bank_state_t sort_upd,
  input  bank_state_t deq_upd,
  output bank_state_t enq_state,
  output bank_state_t sort_state,
  output bank_state_t deq_state,
  input  wr_t         enq_wr,
  input  wr_t         sort_wr,
  input  rd_t         sort_rd,
  input  rd_t         deq_rd,
  output w_t          sort_rd_data,
  output w_t          deq_rd_data
);

  localparam bank_state_t BANK_INIT = '{status: BANK_READY, n: '0, err: 1'b0};

  bank_state_t st_q [N_BANKS];
  wr_t         ram_wr [N_BANKS];
  rd_t         ram_rd [N_BANKS];
  w_t          ram_rd_data [N_BANKS];
  // Bank each stage addressed on the previous cycle
  bank_id_t    sort_rd_idx_q;
  bank_id_t    deq_rd_idx_q;

  // Updates never collide since each status has one writer
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N_BANKS; i++) begin
        st_q[i] <= BANK_INIT;
      end
      sort_rd_idx_q <= '0;
      deq_rd_idx_q  <= '0;
    end else begin
      if (enq_upd_vld) begin
        st_q[enq_idx] <= enq_upd;
      end
      if (sort_upd_vld) begin
        st_q[sort_idx] <= sort_upd;
      end
      if (deq_upd_vld) begin
        st_q[deq_idx] <= deq_upd;
      end
      sort_rd_idx_q <= sort_idx;
      deq_rd_idx_q  <= deq_idx;
    end
  end

  assign enq_state  = st_q[enq_idx];
  assign sort_state = st_q[sort_idx];
  assign deq_state  = st_q[deq_idx];

  // Writes from enqueue while filling, else from sort
  // Reads from dequeue while sorted or unloading, else from sort
  always_comb begin
    for (int i = 0; i < N_BANKS; i++) begin
      ram_wr[i] = '0;
      ram_rd[i] = '0;
      if (st_q[i].status inside {BANK_READY, BANK_LOADING}) begin
        if (enq_idx == bank_id_t'(i)) begin
          ram_wr[i] = enq_wr;
        end
      end else if (sort_idx == bank_id_t'(i)) begin
        ram_wr[i] = sort_wr;
      end
      if (st_q[i].status inside {BANK_SORTED, BANK_UNLOADING}) begin
        if (deq_idx == bank_id_t'(i)) begin
          ram_rd[i] = deq_rd;
        end
      end else if (sort_idx == bank_id_t'(i)) begin
        ram_rd[i] = sort_rd;
      end
    end
  end

  for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
    qs_bank_ram #(
      .N_WORDS (N_WORDS)
    ) u_ram (
      .clk     (clk),
      .wr      (ram_wr[g]),
      .rd      (ram_rd[g]),
      .rd_data (ram_rd_data[g])
    );
  end

  // Read data back to the stage that issued the read
  assign sort_rd_data = ram_rd_data[sort_rd_idx_q];
  assign deq_rd_data  = ram_rd_data[deq_rd_idx_q];

endmodule

//--- hw/qs_top.sv
// Packet sorter top level
//   enqueue, sort and dequeue stages
//   shared bank scoreboard and storage
`timescale 1ns/1ps

module qs_top import qs_pkg::*; #(
  parameter int N_WORDS = N,
  parameter int N_BANKS = BANKS
) (
  input  logic clk,
  input  logic rst,
  input  logic in_vld,
  input  logic in_sop,
  input  logic in_eop,
  input  logic in_err,
  input  w_t   in_dat,
  output logic in_full,
  output logic out_vld,
  output logic out_sop,
  output logic out_eop,
  output logic out_err,
  output w_t   out_dat
);

  // Stage bank indexes
  bank_id_t    enq_idx;
  bank_id_t    sort_idx;
  bank_id_t    deq_idx;
  // Scoreboard traffic
  logic        enq_upd_vld;
  logic        sort_upd_vld;
  logic        deq_upd_vld;
  bank_state_t enq_upd;
  bank_state_t sort_upd;
  bank_state_t deq_upd;
  bank_state_t enq_state;
  bank_state_t sort_state;
  bank_state_t deq_state;
  // RAM traffic
  wr_t         enq_wr;
  wr_t         sort_wr;
  rd_t         sort_rd;
  rd_t         deq_rd;
  w_t          sort_rd_data;
  w_t          deq_rd_data;

  qs_enq #(
    .N_WORDS (N_WORDS)
  ) u_enq (
    .clk          (clk),
    .rst          (rst),
    .in_vld       (in_vld),
    .in_sop       (in_sop),
    .in_eop       (in_eop),
    .in_err       (in_err),
    .in_dat       (in_dat),
    .in_full      (in_full),
    .bank_in      (enq_state),
    .bank_idx_r   (enq_idx),
    .bank_out_vld (enq_upd_vld),
    .bank_out     (enq_upd),
    .wr           (enq_wr)
  );

  qs_sort u_sort (
    .clk          (clk),
    .rst          (rst),
    .bank_in      (sort_state),
    .bank_idx_r   (sort_idx),
    .bank_out_vld (sort_upd_vld),
    .bank_out     (sort_upd),
    .rd           (sort_rd),
    .rd_data      (sort_rd_data),
    .wr           (sort_wr)
  );

  qs_deq u_deq (
    .clk          (clk),
    .rst          (rst),
    .out_vld_r    (out_vld),
    .out_sop_r    (out_sop),
    .out_eop_r    (out_eop),
    .out_err_r    (out_err),
    .out_dat_r    (out_dat),
    .bank_idx_r   (deq_idx),
    .bank_in      (deq_state),
    .bank_out_vld (deq_upd_vld),
    .bank_out     (deq_upd),
    .rd           (deq_rd),
    .rd_data_r    (deq_rd_data)
  );

  qs_banks #(
    .N_BANKS (N_BANKS),
    .N_WORDS (N_WORDS)
  ) u_banks (
    .clk          (clk),
    .rst          (rst),
    .enq_idx      (enq_idx),
    .sort_idx     (sort_idx),
    .deq_idx      (deq_idx),
    .enq_upd_vld  (enq_upd_vld),
    .sort_upd_vld (sort_upd_vld),
    .deq_upd_vld  (deq_upd_vld),
    .enq_upd      (enq_upd),
    .sort_upd     (sort_upd),
    .deq_upd      (deq_upd),
    .enq_state    (enq_state),
    .sort_state   (sort_state),
    .deq_state    (deq_state),
    .enq_wr       (enq_wr),
    .sort_wr      (sort_wr),
    .sort_rd      (sort_rd),
    .deq_rd       (deq_rd),
    .sort_rd_data (sort_rd_data),
    .deq_rd_data  (deq_rd_data)
  );

endmodule

//--- testbench/qs_props.sv
// Concurrent assertions for the packet sorter
//   output strobes and reset behavior
//   input start discipline against in_full
//   packet length bound on the output
`timescale 1ns/1ps

module qs_props (
  input logic clk,
  input logic rst,
  input logic in_vld,
  input logic in_sop,
  input logic in_full,
  input logic out_vld,
  input logic out_sop,
  input logic out_eop
);

  // Output idle through reset, first reset edge skipped
  a_rst_quiet: assert property (@(posedge clk) (rst && $past(rst)) |-> !out_vld)
    else $error("out_vld high during reset");

  // Framing strobes only with a valid word
  a_strobe_vld: assert property (@(posedge clk) disable iff (rst)
    (out_sop || out_eop) |-> out_vld)
    else $error("out_sop or out_eop without out_vld");

  // Source must hold off a packet start while full
  a_sop_full: assert property (@(posedge clk) disable iff (rst)
    (in_vld && in_sop) |-> !in_full)
    else $error("packet start accepted while in_full high");

  // No output stall, so 16 words means 16 cycles
  a_eop_bound: assert property (@(posedge clk) disable iff (rst)
    (out_vld && out_sop) |-> ##[0:15] (out_vld && out_eop))
    else $error("out_eop missing within 16 words of out_sop");

endmodule

//--- testbench/qs_checker.sv
// Output checker for the packet sorter
//   expected packet queue filled by the testbench
//   per-word compare of data, err and framing
//   error counter
`timescale 1ns/1ps

module qs_checker import qs_pkg::*; (
  input logic clk,
  input logic rst,
  input logic out_vld,
  input logic out_sop,
  input logic out_eop,
  input logic out_err,
  input w_t   out_dat
);

  // Expected words of all pending packets, back to back
  w_t   exp_words [$];
  int   exp_len [$];
  logic exp_err [$];
  int   err_cnt = 0;
  int   idx = 0;
  logic in_pkt = 1'b0;

  function automatic void push_word(w_t w);
    exp_words.push_back(w);
  endfunction

  function automatic void push_packet(int len, logic err);
    exp_len.push_back(len);
    exp_err.push_back(err);
  endfunction

  function automatic int pending();
    return exp_len.size();
  endfunction

  function automatic void log_mismatch(string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    err_cnt++;
  endfunction

  // Drop what is left of the current packet
  function automatic void close_packet();
    for (int i = idx; i < exp_len[0]; i++) begin
      void'(exp_words.pop_front());
    end
    void'(exp_len.pop_front());
    void'(exp_err.pop_front());
    in_pkt = 1'b0;
  endfunction

  // Sampled mid-cycle, away from the registered output edge
  always @(negedge clk) begin
    if (rst) begin
      in_pkt = 1'b0;
    end else if (out_vld) begin
      if (out_sop) begin
        if (in_pkt) begin
          log_mismatch("out_sop inside an open packet");
          close_packet();
        end
        if (exp_len.size() == 0) begin
          log_mismatch("output packet with no packet sent");
        end else begin
          in_pkt = 1'b1;
          idx    = 0;
        end
      end
      if (!in_pkt) begin
        if (!out_sop) begin
          log_mismatch("output word outside a packet");
        end
      end else begin
        if (idx < exp_len[0]) begin
          if (out_dat !== exp_words[0]) begin
            log_mismatch($sformatf("word %0d is %h, expected %h", idx, out_dat, exp_words[0]));
          end
          if (out_err !== exp_err[0]) begin
            log_mismatch($sformatf("word %0d err is %b, expected %b", idx, out_err, exp_err[0]));
          end
          void'(exp_words.pop_front());
        end else begin
          log_mismatch($sformatf("extra word %0d beyond length %0d", idx, exp_len[0]));
        end
        // eop exactly on the last expected word
        if (out_eop !== (idx == exp_len[0] - 1)) begin
          log_mismatch($sformatf("out_eop is %b on word %0d of %0d", out_eop, idx, exp_len[0]));
        end
        idx++;
        if (out_eop) begin
          close_packet();
        end
      end
    end
  end

endmodule

//--- testbench/tb_qs.sv
// Testbench top for the packet sorter
//   clock, reset and random packet stimulus
//   sorted model entries handed to the checker
//   drain wait and closing report
`timescale 1ns/1ps

module tb_qs
  import qs_pkg::*;
();

  localparam int MAX_LEN    = 18;
  localparam int FULL_WAIT  = 2000;
  localparam int DRAIN_WAIT = 20000;

  logic clk = 1'b0;
  logic rst;
  logic in_vld;
  logic in_sop;
  logic in_eop;
  logic in_err;
  w_t   in_dat;
  logic in_full;
  logic out_vld;
  logic out_sop;
  logic out_eop;
  logic out_err;
  w_t   out_dat;

  int seed        = 71;
  int tb_err_cnt  = 0;
  int timeout_cnt = 0;
  int sent_cnt    = 0;
  // Words as sent, and the model copy that gets sorted
  w_t send_buf [MAX_LEN];
  w_t model_buf [MAX_LEN];

  always #50 clk = ~clk;

  qs_top #(
    .N_WORDS (N),
    .N_BANKS (BANKS)
  ) u_qs_top (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (in_vld),
    .in_sop  (in_sop),
    .in_eop  (in_eop),
    .in_err  (in_err),
    .in_dat  (in_dat),
    .in_full (in_full),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_err (out_err),
    .out_dat (out_dat)
  );

  qs_checker u_chk (
    .clk     (clk),
    .rst     (rst),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop),
    .out_err (out_err),
    .out_dat (out_dat)
  );

  bind qs_top qs_props u_props (
    .clk     (clk),
    .rst     (rst),
    .in_vld  (in_vld),
    .in_sop  (in_sop),
    .in_full (in_full),
    .out_vld (out_vld),
    .out_sop (out_sop),
    .out_eop (out_eop)
  );

  // Insertion sort, ascending unsigned
  function automatic void sort_model(int len);
    w_t key;
    int j;
    for (int i = 1; i < len; i++) begin
      key = model_buf[i];
      j   = i - 1;
      while (j >= 0 && model_buf[j] > key) begin
        model_buf[j + 1] = model_buf[j];
        j--;
      end
      model_buf[j + 1] = key;
    end
  endfunction

  task automatic idle_cycles(input int n);
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_packet(input int len, input logic err_flag, input w_t key_mask);
    int tries;
    int keep;
    tries = 0;
    // DUT keeps only the first N words
    keep  = (len > N) ? N : len;
    for (int i = 0; i < len; i++) begin
      send_buf[i]  = w_t'($random(seed)) & key_mask;
      model_buf[i] = send_buf[i];
    end
    sort_model(keep);
    in_vld = 1'b0;
    while (in_full && tries < FULL_WAIT) begin
      @(posedge clk);
      #1;
      tries++;
    end
    if (in_full) begin
      $display("Timeout: in_full stayed high, packet %0d never started", sent_cnt);
      timeout_cnt++;
    end else begin
      for (int i = 0; i < keep; i++) begin
        u_chk.push_word(model_buf[i]);
      end
      u_chk.push_packet(keep, err_flag || (len > N));
      sent_cnt++;
      for (int i = 0; i < len; i++) begin
        in_vld = 1'b1;
        in_sop = (i == 0);
        in_eop = (i == len - 1);
        in_err = err_flag;
        in_dat = send_buf[i];
        @(posedge clk);
        #1;
      end
      in_vld = 1'b0;
      in_sop = 1'b0;
      in_eop = 1'b0;
      in_err = 1'b0;
      in_dat = '0;
    end
  endtask

  initial begin
    int   len;
    int   tries;
    logic err_flag;
    w_t   mask;
    rst    = 1'b1;
    in_vld = 1'b0;
    in_sop = 1'b0;
    in_eop = 1'b0;
    in_err = 1'b0;
    in_dat = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    // Quiet DUT after reset
    repeat (20) begin
      if (in_full !== 1'b0 || out_vld !== 1'b0) begin
        $display("[ERROR] %0t: in_full or out_vld high with no traffic", $time);
        tb_err_cnt++;
      end
      @(posedge clk);
      #1;
    end

    // Directed corner packets
    send_packet(1, 1'b0, '1);
    send_packet(6, 1'b0, w_t'(1));
    send_packet(16, 1'b0, '1);
    send_packet(17, 1'b0, '1);
    send_packet(4, 1'b1, '1);
    idle_cycles(3);
    // Three starts back to back, in_full does the throttling
    send_packet(5, 1'b0, '1);
    send_packet(9, 1'b0, '1);
    send_packet(2, 1'b0, w_t'(3));

    // Random lengths, small key ranges now and then
    for (int p = 0; p < 60 && timeout_cnt == 0; p++) begin
      len      = 1 + int'($unsigned($random(seed)) % MAX_LEN);
      err_flag = ($unsigned($random(seed)) % 8) == 0;
      mask     = (($unsigned($random(seed)) % 4) == 0) ? w_t'(3) : '1;
      send_packet(len, err_flag, mask);
      idle_cycles(int'($unsigned($random(seed)) % 4));
    end

    // Drain all expected packets
    tries = 0;
    while (u_chk.pending() != 0 && tries < DRAIN_WAIT) begin
      @(posedge clk);
      #1;
      tries++;
    end
    if (u_chk.pending() != 0) begin
      $display("Timeout: %0d packets never left the sorter", u_chk.pending());
      timeout_cnt++;
    end
    idle_cycles(20);

    $display("Errors: %0d checker, %0d testbench, %0d timeouts, %0d packets",
             u_chk.err_cnt, tb_err_cnt, timeout_cnt, sent_cnt);
    if (u_chk.err_cnt == 0 && tb_err_cnt == 0 && timeout_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- sim.f
hw/qs_pkg.sv
hw/qs_bank_ram.sv
hw/qs_enq.sv
hw/qs_sort.sv
hw/qs_deq.sv
hw/qs_banks.sv
hw/qs_top.sv
testbench/qs_props.sv
testbench/qs_checker.sv
testbench/tb_qs.sv
